// ==== verilog/qfix_pkg.sv ====
package qfix_pkg;

	////////////////////////////////////////////////////////////
	// Word format
	////////////////////////////////////////////////////////////

	// Sign-magnitude Q16.15
	// One sign bit, 16 integer bits, 15 fraction bits
	localparam int QFIX_N = 32;

	// Fraction bits below the binary point
	localparam int QFIX_Q = 15;

	// Magnitude field width, everything but the sign
	localparam int QFIX_MAG_W = 31;

	////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////

	// Two-bit operation select on the request port
	localparam logic [1:0] QFIX_OP_ADD = 2'd0;
	localparam logic [1:0] QFIX_OP_SUB = 2'd1;
	localparam logic [1:0] QFIX_OP_MUL = 2'd2;
	localparam logic [1:0] QFIX_OP_DIV = 2'd3;

	////////////////////////////////////////////////////////////
	// Divider sequencing
	////////////////////////////////////////////////////////////

	// Step counter width
	// Must hold QFIX_DIV_STEPS - 1
	localparam int QFIX_DIV_CNT_W = 6;

	// Quotient bits developed, one per clock
	// Magnitude width plus fraction bits, so the whole
	// integer quotient of (a << 15) / b fits
	localparam logic [QFIX_DIV_CNT_W-1:0] QFIX_DIV_STEPS = 6'd46;

	////////////////////////////////////////////////////////////
	// Word views
	////////////////////////////////////////////////////////////

	// Same 32 bits read two ways
	// raw for storage and the result bus
	// sm for the arithmetic blocks
	typedef union packed {
		logic [QFIX_N-1:0] raw;
		struct packed {
			// Set for negative values
			logic                  sign;
			// Unsigned integer and fraction bits
			logic [QFIX_MAG_W-1:0] mag;
		} sm;
	} qfix_word_u;

endpackage

// ==== verilog/qfix_add.sv ====
module qfix_add (
	input  qfix_pkg::qfix_word_u a,
	input  qfix_pkg::qfix_word_u b,
	output qfix_pkg::qfix_word_u sum,
	output logic                 sum_ovf
);

	// Magnitude sum with room for the carry
	logic [qfix_pkg::QFIX_MAG_W:0]   mag_sum;
	// Larger minus smaller magnitude
	logic [qfix_pkg::QFIX_MAG_W-1:0] mag_diff;
	logic                            a_ge_b;
	logic [qfix_pkg::QFIX_MAG_W-1:0] res_mag;
	logic                            res_sign;

	// Both paths computed every cycle
	// Sign comparison picks one
	always_comb begin
		mag_sum = {1'b0, a.sm.mag} + {1'b0, b.sm.mag};
		a_ge_b  = (a.sm.mag >= b.sm.mag);

		// Always subtract the smaller from the larger
		if (a_ge_b) begin
			mag_diff = a.sm.mag - b.sm.mag;
		end else begin
			mag_diff = b.sm.mag - a.sm.mag;
		end

		if (a.sm.sign == b.sm.sign) begin
			// Same sign so magnitudes add
			// Carry out of bit 30 is the overflow
			// Magnitude wraps
			res_mag  = mag_sum[qfix_pkg::QFIX_MAG_W-1:0];
			res_sign = a.sm.sign;
			sum_ovf  = mag_sum[qfix_pkg::QFIX_MAG_W];
		end else begin
			// Mixed signs never overflow
			// Result takes the sign of the larger operand
			res_mag  = mag_diff;
			res_sign = a_ge_b ? a.sm.sign : b.sm.sign;
			sum_ovf  = 1'b0;
		end

		// No negative zero
		sum.sm.sign = res_sign & (|res_mag);
		sum.sm.mag  = res_mag;
	end

endmodule

// ==== verilog/qfix_mult.sv ====
module qfix_mult (
	input  qfix_pkg::qfix_word_u a,
	input  qfix_pkg::qfix_word_u b,
	output qfix_pkg::qfix_word_u prod,
	output logic                 prod_ovf
);

	////////////////////////////////////////////////////////////
	// Magnitude product
	////////////////////////////////////////////////////////////

	// Full 31 x 31 product, 62 bits
	// Carries 30 fraction bits
	logic [2*qfix_pkg::QFIX_MAG_W-1:0] full_prod;

	// Window after dropping Q fraction bits
	logic [qfix_pkg::QFIX_MAG_W-1:0]   aligned_mag;

	// Bits above the kept window
	logic [2*qfix_pkg::QFIX_MAG_W-1:qfix_pkg::QFIX_Q+qfix_pkg::QFIX_MAG_W] high_bits;

	// Sign before the zero fix
	logic                              raw_sign;

	// Unsigned multiply of the two magnitudes
	assign full_prod = {{qfix_pkg::QFIX_MAG_W{1'b0}}, a.sm.mag} *
		{{qfix_pkg::QFIX_MAG_W{1'b0}}, b.sm.mag};

	////////////////////////////////////////////////////////////
	// Alignment and overflow
	////////////////////////////////////////////////////////////

	// Keep bits 45 down to 15
	// Dropped low bits truncate toward zero
	assign aligned_mag = full_prod[qfix_pkg::QFIX_Q +: qfix_pkg::QFIX_MAG_W];

	// Bits 61 down to 46
	// Integer part beyond 16 bits
	assign high_bits =
		full_prod[2*qfix_pkg::QFIX_MAG_W-1:qfix_pkg::QFIX_Q+qfix_pkg::QFIX_MAG_W];

	// Any lost integer bit flags overflow
	assign prod_ovf = |high_bits;

	////////////////////////////////////////////////////////////
	// Result sign
	////////////////////////////////////////////////////////////

	// Negative when exactly one operand is negative
	assign raw_sign = a.sm.sign ^ b.sm.sign;

	always_comb begin
		prod.sm.mag  = aligned_mag;
		// Zero after truncation is positive
		prod.sm.sign = raw_sign & (|aligned_mag);
	end

endmodule

// ==== verilog/qfix_div.sv ====
module qfix_div (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 div_start,
	input  qfix_pkg::qfix_word_u a,
	input  qfix_pkg::qfix_word_u b,
	output qfix_pkg::qfix_word_u quot,
	output logic                 quot_ovf,
	output logic                 div_done
);

	////////////////////////////////////////////////////////////
	// Datapath registers
	////////////////////////////////////////////////////////////

	// Partial remainder
	// Starts as dividend magnitude << 15
	logic [qfix_pkg::QFIX_DIV_STEPS-1:0]                    rem;

	// Divisor magnitude, starts shifted up by 45
	// Moves right one place per step
	logic [qfix_pkg::QFIX_MAG_W+qfix_pkg::QFIX_DIV_STEPS-2:0] dvs;

	// Quotient bits, MSB first
	logic [qfix_pkg::QFIX_DIV_STEPS-1:0]                    quo;

	// Result sign held for the whole run
	logic                                                   neg;

	// Sequencing
	logic                                                   running;
	logic [qfix_pkg::QFIX_DIV_CNT_W-1:0]                    step_cnt;

	// Step decision
	logic                                                   dvs_high_zero;
	logic                                                   fits;

	// Divisor still larger than any remainder while its
	// upper bits are set
	assign dvs_high_zero =
		~|dvs[qfix_pkg::QFIX_MAG_W+qfix_pkg::QFIX_DIV_STEPS-2:qfix_pkg::QFIX_DIV_STEPS];

	// Shifted divisor fits under the remainder
	// Zero divisor always fits, so every bit sets
	assign fits = dvs_high_zero && (rem >= dvs[qfix_pkg::QFIX_DIV_STEPS-1:0]);

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running  <= 1'b0;
			step_cnt <= '0;
			div_done <= 1'b0;
		end else begin
			// Single-cycle pulse
			div_done <= 1'b0;
			if (div_start) begin
				running  <= 1'b1;
				step_cnt <= qfix_pkg::QFIX_DIV_STEPS - 1'b1;
			end else if (running) begin
				step_cnt <= step_cnt - 1'b1;
				// Last bit lands on this edge
				if (step_cnt == '0) begin
					running  <= 1'b0;
					div_done <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Restoring steps
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (div_start) begin
			rem <= {a.sm.mag, {qfix_pkg::QFIX_Q{1'b0}}};
			dvs <= {b.sm.mag, {(qfix_pkg::QFIX_DIV_STEPS-1){1'b0}}};
			quo <= '0;
			neg <= a.sm.sign ^ b.sm.sign;
		end else if (running) begin
			// Subtract only when it fits
			if (fits) begin
				rem <= rem - dvs[qfix_pkg::QFIX_DIV_STEPS-1:0];
			end
			quo <= {quo[qfix_pkg::QFIX_DIV_STEPS-2:0], fits};
			dvs <= dvs >> 1;
		end
	end

	// Low 31 bits form the magnitude
	// Anything above is integer overflow
	always_comb begin
		quot.sm.mag  = quo[qfix_pkg::QFIX_MAG_W-1:0];
		quot.sm.sign = neg & (|quo[qfix_pkg::QFIX_MAG_W-1:0]);
		quot_ovf     = |quo[qfix_pkg::QFIX_DIV_STEPS-1:qfix_pkg::QFIX_MAG_W];
	end

endmodule

// ==== verilog/qfix_ctrl_regs.sv ====
module qfix_ctrl_regs (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        start,
	input  logic [1:0]                  op,
	input  logic [qfix_pkg::QFIX_N-1:0] a,
	input  logic [qfix_pkg::QFIX_N-1:0] b,
	input  qfix_pkg::qfix_word_u        sum,
	input  logic                        sum_ovf,
	input  qfix_pkg::qfix_word_u        prod,
	input  logic                        prod_ovf,
	input  qfix_pkg::qfix_word_u        quot,
	input  logic                        quot_ovf,
	input  logic                        div_done,
	output qfix_pkg::qfix_word_u        op_a,
	output qfix_pkg::qfix_word_u        op_b_add,
	output qfix_pkg::qfix_word_u        op_b,
	output logic                        div_start,
	output logic [qfix_pkg::QFIX_N-1:0] result,
	output logic                        overflow,
	output logic                        done,
	output logic                        busy
);

	// Held request
	logic [1:0]           op_q;
	qfix_pkg::qfix_word_u a_q;
	qfix_pkg::qfix_word_u b_q;

	logic                 accept;
	logic                 capture;
	qfix_pkg::qfix_word_u sel_word;
	logic                 sel_ovf;

	// Starts during busy are dropped
	assign accept = start & ~busy;

	// One cycle for add, sub and mul
	// Divide waits for the divider pulse
	assign capture = busy & ((op_q != qfix_pkg::QFIX_OP_DIV) | div_done);

	// Operand registers, loaded only on accept
	always_ff @(posedge clk) begin
		if (accept) begin
			a_q.raw <= a;
			b_q.raw <= b;
		end
	end

	assign op_a = a_q;
	assign op_b = b_q;

	always_comb begin
		// Subtract is add with b negated
		op_b_add.sm.sign = b_q.sm.sign ^ (op_q == qfix_pkg::QFIX_OP_SUB);
		op_b_add.sm.mag  = b_q.sm.mag;

		// Pick the block that owns the held opcode
		case (op_q)
			qfix_pkg::QFIX_OP_MUL: begin
				sel_word = prod;
				sel_ovf  = prod_ovf;
			end
			qfix_pkg::QFIX_OP_DIV: begin
				sel_word = quot;
				sel_ovf  = quot_ovf;
			end
			default: begin
				sel_word = sum;
				sel_ovf  = sum_ovf;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Issue and completion
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_q      <= qfix_pkg::QFIX_OP_ADD;
			busy      <= 1'b0;
			done      <= 1'b0;
			div_start <= 1'b0;
			result    <= '0;
			overflow  <= 1'b0;
		end else begin
			done      <= capture;
			div_start <= accept & (op == qfix_pkg::QFIX_OP_DIV);
			if (accept) begin
				op_q <= op;
				busy <= 1'b1;
			end else if (capture) begin
				busy <= 1'b0;
			end
			// Result holds until the next completion
			if (capture) begin
				result   <= sel_word.raw;
				overflow <= sel_ovf;
			end
		end
	end

endmodule

// ==== verilog/qfix_alu.sv ====
module qfix_alu (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        start,
	input  logic [1:0]                  op,
	input  logic [qfix_pkg::QFIX_N-1:0] a,
	input  logic [qfix_pkg::QFIX_N-1:0] b,
	output logic [qfix_pkg::QFIX_N-1:0] result,
	output logic                        overflow,
	output logic                        done,
	output logic                        busy
);

	////////////////////////////////////////////////////////////
	// Internal nets
	////////////////////////////////////////////////////////////

	// Held operands from the register block
	qfix_pkg::qfix_word_u op_a;
	qfix_pkg::qfix_word_u op_b;
	// b with the sign flipped on subtract
	qfix_pkg::qfix_word_u op_b_add;

	// Arithmetic results back to the register block
	qfix_pkg::qfix_word_u sum;
	qfix_pkg::qfix_word_u prod;
	qfix_pkg::qfix_word_u quot;
	logic                 sum_ovf;
	logic                 prod_ovf;
	logic                 quot_ovf;

	// Divider handshake
	logic                 div_start;
	logic                 div_done;

	qfix_ctrl_regs ctrl_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.op       (op),
		.a        (a),
		.b        (b),
		.sum      (sum),
		.sum_ovf  (sum_ovf),
		.prod     (prod),
		.prod_ovf (prod_ovf),
		.quot     (quot),
		.quot_ovf (quot_ovf),
		.div_done (div_done),
		.op_a     (op_a),
		.op_b_add (op_b_add),
		.op_b     (op_b),
		.div_start(div_start),
		.result   (result),
		.overflow (overflow),
		.done     (done),
		.busy     (busy)
	);

	// Add and subtract share one adder
	qfix_add add_i (
		.a      (op_a),
		.b      (op_b_add),
		.sum    (sum),
		.sum_ovf(sum_ovf)
	);

	qfix_mult mult_i (
		.a       (op_a),
		.b       (op_b),
		.prod    (prod),
		.prod_ovf(prod_ovf)
	);

	qfix_div div_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.div_start(div_start),
		.a        (op_a),
		.b        (op_b),
		.quot     (quot),
		.quot_ovf (quot_ovf),
		.div_done (div_done)
	);

endmodule

// ==== test/qfix_alu_checker.sv ====
module qfix_alu_checker (
	input logic                        clk,
	input logic                        rst_n,
	input logic [qfix_pkg::QFIX_N-1:0] result,
	input logic                        overflow,
	input logic                        done,
	input logic                        busy
);

	// Failed assertions so far
	int unsigned fail_count = 0;

	// Done is a single-cycle pulse
	done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else begin
			$error("done high on two consecutive cycles");
			fail_count++;
		end

	// Quiet outputs while reset is held
	reset_quiet: assert property (@(posedge clk) !rst_n |-> (!done && !busy))
		else begin
			$error("done or busy high during reset");
			fail_count++;
		end

	// Result register only moves on completion
	result_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(!$stable(result) || !$stable(overflow)) |-> done)
		else begin
			$error("result or overflow changed without done");
			fail_count++;
		end

endmodule

bind qfix_alu qfix_alu_checker protocol_chk (
	.clk     (clk),
	.rst_n   (rst_n),
	.result  (result),
	.overflow(overflow),
	.done    (done),
	.busy    (busy)
);

// ==== test/qfix_alu_tb.sv ====
module qfix_alu_tb;

	// Five words per vector
	// op, a, b, expected result, expected overflow
	localparam int          VEC_WORDS = 5;
	localparam int          MAX_VEC   = 64;
	// Opcode word closing the list
	localparam logic [31:0] END_MARK  = 32'h0000_00ff;
	localparam logic [31:0] LFSR_SEED = 32'hf94e_4c3c;

	logic                        clk;
	logic                        rst_n;
	logic                        start;
	logic [1:0]                  op;
	logic [qfix_pkg::QFIX_N-1:0] a;
	logic [qfix_pkg::QFIX_N-1:0] b;
	logic [qfix_pkg::QFIX_N-1:0] result;
	logic                        overflow;
	logic                        done;
	logic                        busy;

	logic [31:0] vec_mem [0:VEC_WORDS*MAX_VEC-1];
	int          n_vec;
	int          tests_run;
	int          tests_failed;
	int          errors;
	int          misses;
	int          done_count;
	logic [31:0] lfsr;

	qfix_alu dut_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.op      (op),
		.a       (a),
		.b       (b),
		.result  (result),
		.overflow(overflow),
		.done    (done),
		.busy    (busy)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Done pulses seen at clock edges
	always @(posedge clk) begin
		if (done) begin
			done_count = done_count + 1;
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h8020_0003;
		end
		return n;
	endfunction

	function automatic string op_name(input logic [1:0] code);
		case (code)
			qfix_pkg::QFIX_OP_ADD: return "add";
			qfix_pkg::QFIX_OP_SUB: return "sub";
			qfix_pkg::QFIX_OP_MUL: return "mul";
			default:               return "div";
		endcase
	endfunction

	// One-cycle start pulse, inputs move 1 unit after the edge
	task automatic issue(input logic [1:0] code, input logic [31:0] x,
		input logic [31:0] y);
		@(posedge clk);
		#1;
		start = 1'b1;
		op    = code;
		a     = x;
		b     = y;
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	// Sampled between edges
	task automatic wait_done;
		while (!done) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic check_value(input string name, input string what,
		input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("MISMATCH %s %s expected %08h actual %08h", name, what, exp, act);
			misses++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		errors += misses;
		if (misses == 0) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: failed, %0d wrong values", name, misses);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int          base;
		int          prev_count;
		logic [1:0]  idle;
		string       name;
		logic [31:0] exp_res;
		logic        exp_ovf;

		rst_n        = 1'b1;
		start        = 1'b0;
		op           = qfix_pkg::QFIX_OP_ADD;
		a            = '0;
		b            = '0;
		n_vec        = 0;
		tests_run    = 0;
		tests_failed = 0;
		errors       = 0;
		misses       = 0;
		done_count   = 0;
		lfsr         = LFSR_SEED;

		$readmemh("test/qfix_testdata.hex", vec_mem);
		while (n_vec < MAX_VEC && vec_mem[n_vec*VEC_WORDS] != END_MARK) begin
			n_vec++;
		end

		// Falling rst_n edge after time zero
		#1;
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Idle outputs before any request
		misses = 0;
		check_value("reset_state", "result", '0, result);
		check_value("reset_state", "overflow", '0, {31'b0, overflow});
		check_value("reset_state", "done", '0, {31'b0, done});
		check_value("reset_state", "busy", '0, {31'b0, busy});
		finish_test("reset_state");

		for (int i = 0; i < n_vec; i++) begin
			base = i * VEC_WORDS;
			// 0 to 3 idle cycles from two LFSR bits
			idle = '0;
			repeat (2) begin
				idle = {idle[0], lfsr[0]};
				lfsr = lfsr_next(lfsr);
			end
			repeat (idle) @(posedge clk);
			name    = $sformatf("%s_%0d", op_name(vec_mem[base][1:0]), i);
			exp_res = vec_mem[base+3];
			exp_ovf = vec_mem[base+4][0];
			misses  = 0;
			issue(vec_mem[base][1:0], vec_mem[base+1], vec_mem[base+2]);
			wait_done();
			check_value(name, "result", exp_res, result);
			check_value(name, "overflow", {31'b0, exp_ovf}, {31'b0, overflow});
			finish_test(name);
		end

		// Add request while a divide runs
		// 7.0 / 2.0 must come back, once
		misses = 0;
		issue(qfix_pkg::QFIX_OP_DIV, 32'h0003_8000, 32'h0001_0000);
		prev_count = done_count;
		repeat (3) @(posedge clk);
		issue(qfix_pkg::QFIX_OP_ADD, 32'h0000_8000, 32'h0000_8000);
		wait_done();
		check_value("busy_start", "result", 32'h0001_c000, result);
		check_value("busy_start", "overflow", '0, {31'b0, overflow});
		// Past the point a second divide would end
		repeat (60) @(posedge clk);
		#1;
		check_value("busy_start", "done pulses", 32'd1, done_count - prev_count);
		finish_test("busy_start");

		$display("tests %0d, failed %0d, wrong values %0d, assertion failures %0d",
			tests_run, tests_failed, errors, dut_i.protocol_chk.fail_count);
		if (tests_failed == 0 && dut_i.protocol_chk.fail_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Watchdog, 60 cycles per vector plus reset and protocol test
	initial begin
		int budget;
		#1;
		budget = 8 + (n_vec + 3) * 60;
		#(budget * 10);
		$display("timeout: run still going after %0d cycles", budget);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== test/qfix_testdata.hex ====
// op a b expected_result expected_overflow
// op 0 add, 1 sub, 2 mul, 3 div; words are sign-magnitude Q16.15; op ff ends the list
// add and sub, equal and mixed signs
0 00008000 00014000 0001C000 0
0 00018000 8000A000 0000E000 0
0 80018000 0000A000 8000E000 0
0 00010000 80010000 00000000 0
1 00008000 00014000 8000C000 0
1 80010000 80010000 00000000 0
1 80008000 00004000 8000C000 0
// carry out of the magnitude, wrapped result
0 40000000 40008000 00008000 1
0 FFFF8000 80010000 80008000 1
1 7FFFFFFF 80000001 00000000 1
// mul, four sign combinations of 1.5 * 2.0
2 0000C000 00010000 00018000 0
2 8000C000 00010000 80018000 0
2 0000C000 80010000 80018000 0
2 8000C000 80010000 00018000 0
// mul fractions and truncation
2 00004000 00002000 00001000 0
2 80000001 00004000 00000000 0
2 00000003 00004000 00000001 0
// mul integer range
2 007F8000 00800000 7F800000 0
2 80C00000 00C00000 A0000000 1
// div exact, truncated, mixed signs
3 00018000 0000C000 00010000 0
3 80018000 0000C000 80010000 0
3 00008000 80018000 80002AAA 0
3 80008000 80020000 00002000 0
3 00000005 00010000 00000002 0
3 00000000 80010000 00000000 0
// div overflow and divide by zero
3 7FFF8000 00004000 7FFF0000 1
3 00018000 00000000 7FFFFFFF 1
3 80018000 00000000 FFFFFFFF 1
// end of list
FF 00000000 00000000 00000000 0

// ==== build.f ====
verilog/qfix_pkg.sv
verilog/qfix_add.sv
verilog/qfix_mult.sv
verilog/qfix_div.sv
verilog/qfix_ctrl_regs.sv
verilog/qfix_alu.sv
test/qfix_alu_checker.sv
test/qfix_alu_tb.sv

// ==== Makefile ====
TOP := qfix_alu_tb

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

# Simulation passes only if the pass line shows up
run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -q '>>> PASS'

lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
